// ==== agcLoopTop.f ====
agcPkg.sv
agcLoopRegs.sv
agcErrorDetector.sv
agcIntegrator.sv
agcChannelGain.sv
agcLoopTop.sv
agcLoopTop_checker.sv
agcLoopTop_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the AGC loop testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module agcLoopTop_tb -f agcLoopTop.f -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// ==== agcLoopTop_tb.sv ====
// Testbench for the AGC loop top level.
// Clock and reset, APB write and read tasks, a random sample
// stream, a cycle model of the loop and the closing summary.

`timescale 1ns/1ps
`default_nettype none

module agcLoopTop_tb;
    import agcPkg::*;

    localparam int TIMEOUT = 50;

    logic busClk, rstN, psel, penable, pwrite, pready, pslverr, sampleValid;
    logic [3:0] pstrb;
    apbAddrT paddr;
    apbDataT pwdata, prdata, gainsBefore;
    sampleMagT sampleMag;
    gainWordT gainOut0, gainOut1;
    int checkCount, errCount;
    logic checkOn, streamOn;

    // shadow configuration and model pipeline.
    logic shZero, shInvert, shBypass, mStepValid, mStepBypass;
    sampleMagT shSetpoint;
    loopGainT shPos, shNeg;
    accumT shUpper, shLower, mAccum;
    ratioT shRatio0, shRatio1;
    longint mStep;
    gainWordT mGain0, mGain1;

    agcLoopTop DUT (
        .busClk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb,
        .prdata, .pready, .pslverr, .sampleValid, .sampleMag, .gainOut0, .gainOut1
    );

    initial begin
        busClk = 1'b0;
        forever #4 busClk = ~busClk;
    end

    function automatic apbDataT laneWrite(input apbDataT oldWord, input apbDataT newWord,
                                          input logic [3:0] strb);
        apbDataT result;
        result = oldWord;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) result[b*8 +: 8] = newWord[b*8 +: 8];
        end
        return result;
    endfunction

    function automatic apbDataT ctrlWord();
        return {3'b000, shNeg, 3'b000, shPos, shSetpoint, 5'b00000, shBypass, shInvert, shZero};
    endfunction

    function automatic longint stepFor(input sampleMagT mag);
        int err;
        err = int'(shSetpoint) - int'(mag);
        if (shZero) err = 0;
        else if (shInvert) err = -err;
        return longint'(err) <<< ((err < 0) ? shNeg : shPos);
    endfunction

    function automatic accumT clampAdd(input accumT acc, input longint stepVal);
        longint sum;
        sum = longint'(acc) + stepVal;
        if (sum > longint'(shUpper)) return shUpper;
        if (sum < longint'(shLower)) return shLower;
        return accumT'(sum);
    endfunction

    function automatic gainWordT gainFor(input accumT acc, input ratioT ratio);
        longint prod;
        prod = (longint'(acc >> 16) * longint'(ratio)) >> 15;
        if (shBypass) return ratio;
        if (prod > 64'hFFFF) return 16'hFFFF;
        return gainWordT'(prod);
    endfunction

    // model state advances on the same edges as the DUT.
    always @(posedge busClk) begin : modelUpdate
        apbDataT merged;
        if (!rstN) begin
            {shZero, shInvert, shBypass, mStepValid, mStepBypass} <= '0;
            shSetpoint <= RST_SETPOINT;
            shPos <= RST_POS_GAIN;
            shNeg <= RST_NEG_GAIN;
            shUpper <= RST_ULIMIT;
            shLower <= RST_LLIMIT;
            shRatio0 <= RST_RATIO;
            shRatio1 <= RST_RATIO;
            mAccum <= '0;
            mStep <= 0;
            mGain0 <= '0;
            mGain1 <= '0;
        end else begin
            if (psel && penable && pwrite) begin
                case (paddr)
                    ADDR_CONTROL: begin
                        merged = laneWrite(ctrlWord(), pwdata, pstrb);
                        {shBypass, shInvert, shZero} <= merged[2:0];
                        shSetpoint <= merged[15:8];
                        shPos <= merged[20:16];
                        shNeg <= merged[28:24];
                    end
                    ADDR_ULIMIT: shUpper <= laneWrite(shUpper, pwdata, pstrb);
                    ADDR_LLIMIT: shLower <= laneWrite(shLower, pwdata, pstrb);
                    ADDR_RATIOS: {shRatio1, shRatio0} <= laneWrite({shRatio1, shRatio0},
                                                                   pwdata, pstrb);
                    default: ;
                endcase
            end
            mStepValid <= sampleValid;
            mStepBypass <= shBypass;
            if (sampleValid) mStep <= stepFor(sampleMag);
            if (mStepValid && !mStepBypass) mAccum <= clampAdd(mAccum, mStep);
            mGain0 <= gainFor(mAccum, shRatio0);
            mGain1 <= gainFor(mAccum, shRatio1);
        end
    end

    always @(posedge busClk) begin
        if (streamOn) begin
            sampleValid <= ($urandom % 4) != 0;
            sampleMag <= 8'($urandom);
        end else begin
            sampleValid <= 1'b0;
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("ERR %s got 0x%h exp 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    always @(negedge busClk) begin
        if (checkOn) begin
            compare("gainOut0", gainOut0, mGain0);
            compare("gainOut1", gainOut1, mGain1);
        end
    end

    task automatic failTimeout(input string what);
        $display("timeout waiting for pready during %s", what);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic writeReg(input apbAddrT addr, input apbDataT data, input logic [3:0] strb,
                            input logic expErr);
        int waitCnt;
        @(posedge busClk);
        psel <= 1'b1;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        pstrb <= strb;
        @(posedge busClk);
        penable <= 1'b1;
        waitCnt = 0;
        @(negedge busClk);
        while (!pready && waitCnt < TIMEOUT) begin
            @(negedge busClk);
            waitCnt++;
        end
        if (!pready) failTimeout("an APB write");
        compare("pslverr", 32'(pslverr), 32'(expErr));
        @(posedge busClk);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    task automatic readCheck(input apbAddrT addr);
        int waitCnt;
        apbDataT exp;
        @(negedge busClk);
        gainsBefore = {mGain1, mGain0};
        @(posedge busClk);
        psel <= 1'b1;
        pwrite <= 1'b0;
        paddr <= addr;
        @(posedge busClk);
        penable <= 1'b1;
        waitCnt = 0;
        @(negedge busClk);
        while (!pready && waitCnt < TIMEOUT) begin
            @(negedge busClk);
            waitCnt++;
        end
        if (!pready) failTimeout("an APB read");
        case (addr)
            ADDR_CONTROL: exp = ctrlWord();
            ADDR_ULIMIT:  exp = shUpper;
            ADDR_LLIMIT:  exp = shLower;
            ADDR_GAINS:   exp = gainsBefore;
            ADDR_RATIOS:  exp = {shRatio1, shRatio0};
            ADDR_ACCUM:   exp = mAccum;
            default:      exp = '0;
        endcase
        compare("prdata", prdata, exp);
        compare("pslverr", 32'(pslverr), 32'(addr inside {ADDR_CONTROL, ADDR_ULIMIT,
                ADDR_LLIMIT, ADDR_GAINS, ADDR_RATIOS, ADDR_ACCUM} ? 1'b0 : 1'b1));
        @(posedge busClk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic readAll();
        readCheck(ADDR_CONTROL);
        readCheck(ADDR_ULIMIT);
        readCheck(ADDR_LLIMIT);
        readCheck(ADDR_GAINS);
        readCheck(ADDR_RATIOS);
        readCheck(ADDR_ACCUM);
    endtask

    task automatic setControl(input logic zero, input logic inv, input logic byp,
                              input int gainSpan);
        writeReg(ADDR_CONTROL, {3'b000, 5'($urandom % gainSpan), 3'b000,
                 5'($urandom % gainSpan), 8'($urandom), 5'b00000, byp, inv, zero},
                 4'hF, 1'b0);
    endtask

    // several samples in flight, with the accumulator read back along the way.
    task automatic runStream(input int rounds);
        for (int r = 0; r < rounds; r++) begin
            repeat ($urandom % 6) @(posedge busClk);
            readCheck(ADDR_ACCUM);
        end
    endtask

    initial begin
        apbAddrT addrSel;
        accumT low;
        void'($urandom(32'h4905_d6ab));
        {rstN, psel, penable, pwrite, sampleValid, checkOn, streamOn} = '0;
        paddr = '0;
        pwdata = '0;
        pstrb = '0;
        sampleMag = '0;
        checkCount = 0;
        errCount = 0;
        repeat (16) @(posedge busClk);
        rstN <= 1'b1;
        @(posedge busClk);
        checkOn <= 1'b1;
        readAll();

        // random byte-lane writes.
        for (int i = 0; i < 40; i++) begin
            case ($urandom % 4)
                0: addrSel = ADDR_CONTROL;
                1: addrSel = ADDR_ULIMIT;
                2: addrSel = ADDR_LLIMIT;
                default: addrSel = ADDR_RATIOS;
            endcase
            writeReg(addrSel, $urandom, 4'($urandom), 1'b0);
            readCheck(addrSel);
        end

        // slave errors leave the registers alone.
        writeReg(ADDR_GAINS, $urandom, 4'hF, 1'b1);
        writeReg(ADDR_ACCUM, $urandom, 4'hF, 1'b1);
        writeReg(6'h18, $urandom, 4'hF, 1'b1);
        writeReg(6'h02, $urandom, 4'hF, 1'b1);
        readCheck(6'h3C);
        readAll();

        writeReg(ADDR_ULIMIT, 32'hFFFF_FFFF, 4'hF, 1'b0);
        writeReg(ADDR_LLIMIT, 32'h0, 4'hF, 1'b0);
        writeReg(ADDR_RATIOS, $urandom, 4'hF, 1'b0);
        streamOn <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            setControl(1'b0, 1'b0, 1'b0, 18);
            runStream(10);
        end

        // narrow limits force clamping at both ends.
        for (int i = 0; i < 8; i++) begin
            low = $urandom & 32'h7FFF_FFFF;
            writeReg(ADDR_LLIMIT, low, 4'hF, 1'b0);
            writeReg(ADDR_ULIMIT, low + ($urandom % 32'h1_0000), 4'hF, 1'b0);
            setControl(1'b0, 1'($urandom), 1'b0, 24);
            runStream(8);
        end

        writeReg(ADDR_LLIMIT, 32'h0, 4'hF, 1'b0);
        writeReg(ADDR_ULIMIT, 32'hFFFF_FFFF, 4'hF, 1'b0);
        setControl(1'b0, 1'b1, 1'b0, 16);
        runStream(10);
        setControl(1'b1, 1'b1, 1'b0, 16);
        runStream(6);
        setControl(1'b0, 1'b0, 1'b1, 16);
        runStream(6);
        @(negedge busClk);
        compare("gainOut0", gainOut0, shRatio0);
        compare("gainOut1", gainOut1, shRatio1);

        // ratios above unity with a large accumulator.
        writeReg(ADDR_RATIOS, 32'hFFFF_C000, 4'hF, 1'b0);
        writeReg(ADDR_LLIMIT, 32'hF000_0000, 4'hF, 1'b0);
        setControl(1'b0, 1'b0, 1'b0, 20);
        repeat (30) @(posedge busClk);
        @(negedge busClk);
        compare("gainOut0", gainOut0, 32'hFFFF);
        compare("gainOut1", gainOut1, 32'hFFFF);
        readCheck(ADDR_GAINS);
        streamOn <= 1'b0;
        repeat (4) @(posedge busClk);

        $display("checks %0d errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== agcLoopTop_checker.sv ====
// Bound assertions for the AGC loop top level.
// Covers the APB handshake and the integrator range.

`timescale 1ns/1ps
`default_nettype none

module agcLoopTop_checker (
    input logic          busClk,
    input logic          rstN,
    input logic          psel,
    input logic          penable,
    input agcPkg::accumT accum,
    input agcPkg::accumT upperLimit,
    input agcPkg::accumT lowerLimit,
    input logic          stepValid,
    input logic          stepBypass
);
    import agcPkg::*;

    // access phase always comes after a setup phase.
    penableAfterPsel: assert property (@(posedge busClk) disable iff (!rstN)
        penable |-> $past(psel))
        else $error("penable without a preceding psel cycle");

    // only checked once an update has used the current limits.
    accumInRange: assert property (@(posedge busClk) disable iff (!rstN)
        (lowerLimit <= upperLimit && $stable(lowerLimit) && $stable(upperLimit) &&
         $past(stepValid) && !$past(stepBypass))
        |-> (accum >= lowerLimit && accum <= upperLimit))
        else $error("accumulator outside its limits");

    stepIdleAfterReset: assert property (@(posedge busClk)
        $rose(rstN) |-> !stepValid)
        else $error("stepValid high right after reset");

endmodule

bind agcLoopTop agcLoopTop_checker uChecker (
    .busClk(busClk), .rstN(rstN), .psel(psel), .penable(penable),
    .accum(accum), .upperLimit(upperLimit), .lowerLimit(lowerLimit),
    .stepValid(stepValid), .stepBypass(stepBypass)
);

`default_nettype wire

// ==== agcLoopTop.sv ====
// Top level of the two-channel AGC loop.
// Connects the APB register block, the error detector,
// the integrator and the two channel gain stages.

`timescale 1ns/1ps
`default_nettype none

module agcLoopTop (
    input  logic              busClk,
    input  logic              rstN,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  agcPkg::apbAddrT   paddr,
    input  agcPkg::apbDataT   pwdata,
    input  logic [3:0]        pstrb,
    output agcPkg::apbDataT   prdata,
    output logic              pready,
    output logic              pslverr,
    input  logic              sampleValid,
    input  agcPkg::sampleMagT sampleMag,
    output agcPkg::gainWordT  gainOut0,
    output agcPkg::gainWordT  gainOut1
);
    import agcPkg::*;

    logic      zeroError;
    logic      invertError;
    logic      bypassAgc;
    sampleMagT agcSetpoint;
    loopGainT  posErrorGain;
    loopGainT  negErrorGain;
    accumT     upperLimit;
    accumT     lowerLimit;
    ratioT     ratio0;
    ratioT     ratio1;
    logic      stepValid;
    stepT      step;
    logic      stepBypass;
    accumT     accum;

    agcLoopRegs uRegs (
        .busClk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb,
        .accum, .gainOut0, .gainOut1, .prdata, .pready, .pslverr,
        .zeroError, .invertError, .bypassAgc, .agcSetpoint,
        .posErrorGain, .negErrorGain, .upperLimit, .lowerLimit, .ratio0, .ratio1
    );

    agcErrorDetector uErrorDetector (
        .busClk, .rstN, .sampleValid, .sampleMag, .agcSetpoint,
        .zeroError, .invertError, .bypassAgc, .posErrorGain, .negErrorGain,
        .stepValid, .step, .stepBypass
    );

    agcIntegrator uIntegrator (
        .busClk, .rstN, .stepValid, .step, .stepBypass,
        .upperLimit, .lowerLimit, .accum
    );

    // one gain stage per receiver channel.
    agcChannelGain uGain0 (
        .busClk, .rstN, .accum, .ratio(ratio0), .bypassAgc, .gainOut(gainOut0)
    );

    agcChannelGain uGain1 (
        .busClk, .rstN, .accum, .ratio(ratio1), .bypassAgc, .gainOut(gainOut1)
    );

endmodule

`default_nettype wire

// ==== agcChannelGain.sv ====
// Per-channel gain stage of the AGC.
// Scales the upper half of the accumulator by the front-end
// ratio and saturates to 16 bits; passes the ratio under bypass.

`timescale 1ns/1ps
`default_nettype none

module agcChannelGain (
    input  logic             busClk,
    input  logic             rstN,
    input  agcPkg::accumT    accum,
    input  agcPkg::ratioT    ratio,
    input  logic             bypassAgc,
    output agcPkg::gainWordT gainOut
);
    import agcPkg::*;

    logic [2*$bits(ratioT)-1:0] product;
    logic [2*$bits(ratioT)-1:0] scaled;
    gainWordT                   gainNext;

    assign product = accum[$bits(accumT)-1 -: $bits(ratioT)] * ratio;
    assign scaled  = product >> RATIO_FRAC_BITS;

    always_comb begin
        if (bypassAgc) begin
            gainNext = ratio;
        end else if (|scaled[2*$bits(ratioT)-1:$bits(gainWordT)]) begin
            // above 0xFFFF.
            gainNext = '1;
        end else begin
            gainNext = scaled[$bits(gainWordT)-1:0];
        end
    end

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            gainOut <= '0;
        end else begin
            gainOut <= gainNext;
        end
    end

endmodule

`default_nettype wire

// ==== agcIntegrator.sv ====
// Loop integrator of the AGC.
// Adds the scaled error to the accumulator, clamps the sum
// to the programmed lower and upper limits, and holds the
// value while the loop is bypassed.

`timescale 1ns/1ps
`default_nettype none

module agcIntegrator (
    input  logic          busClk,
    input  logic          rstN,
    input  logic          stepValid,
    input  agcPkg::stepT  step,
    input  logic          stepBypass,
    input  agcPkg::accumT upperLimit,
    input  agcPkg::accumT lowerLimit,
    output agcPkg::accumT accum
);
    import agcPkg::*;

    // one bit wider than the step, so the sum never wraps.
    logic signed [$bits(stepT):0] stepExt;
    logic signed [$bits(stepT):0] accumExt;
    logic signed [$bits(stepT):0] upperExt;
    logic signed [$bits(stepT):0] lowerExt;
    logic signed [$bits(stepT):0] sum;
    accumT                        accumNext;

    assign stepExt  = {step[$bits(stepT)-1], step};
    assign accumExt = {{($bits(stepT)+1-$bits(accumT)){1'b0}}, accum};
    assign upperExt = {{($bits(stepT)+1-$bits(accumT)){1'b0}}, upperLimit};
    assign lowerExt = {{($bits(stepT)+1-$bits(accumT)){1'b0}}, lowerLimit};
    assign sum      = accumExt + stepExt;

    // upper bound is checked first.
    always_comb begin
        if (sum > upperExt) begin
            accumNext = upperLimit;
        end else if (sum < lowerExt) begin
            accumNext = lowerLimit;
        end else begin
            accumNext = sum[$bits(accumT)-1:0];
        end
    end

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            accum <= RST_LLIMIT;
        end else if (stepValid && !stepBypass) begin
            accum <= accumNext;
        end
    end

endmodule

`default_nettype wire

// ==== agcErrorDetector.sv ====
// Setpoint error stage of the AGC loop.
// Forms setpoint minus magnitude, applies zero and invert,
// scales by the positive or negative shift gain and registers
// the step together with its valid and bypass flags.

`timescale 1ns/1ps
`default_nettype none

module agcErrorDetector (
    input  logic              busClk,
    input  logic              rstN,
    input  logic              sampleValid,
    input  agcPkg::sampleMagT sampleMag,
    input  agcPkg::sampleMagT agcSetpoint,
    input  logic              zeroError,
    input  logic              invertError,
    input  logic              bypassAgc,
    input  agcPkg::loopGainT  posErrorGain,
    input  agcPkg::loopGainT  negErrorGain,
    output logic              stepValid,
    output agcPkg::stepT      step,
    output logic              stepBypass
);
    import agcPkg::*;

    errorT    rawError;
    errorT    error;
    loopGainT shiftGain;
    stepT     stepNext;

    always_comb begin
        rawError = $signed({1'b0, agcSetpoint}) - $signed({1'b0, sampleMag});
        // zero wins over invert.
        if (zeroError) begin
            error = '0;
        end else if (invertError) begin
            error = -rawError;
        end else begin
            error = rawError;
        end
        shiftGain = (error < 0) ? negErrorGain : posErrorGain;
        stepNext  = stepT'(error) <<< shiftGain;
    end

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            stepValid  <= 1'b0;
            stepBypass <= 1'b0;
        end else begin
            stepValid  <= sampleValid;
            stepBypass <= bypassAgc;
        end
    end

    always_ff @(posedge busClk) begin
        if (sampleValid) begin
            step <= stepNext;
        end
    end

endmodule

`default_nettype wire

// ==== agcLoopRegs.sv ====
// APB register block of the AGC loop.
// Holds control, limits and ratios with byte-lane writes,
// the read-back multiplexer, slave error flagging and the
// tear-free snapshot of both gain words.

`timescale 1ns/1ps
`default_nettype none

module agcLoopRegs (
    input  logic              busClk,
    input  logic              rstN,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  agcPkg::apbAddrT   paddr,
    input  agcPkg::apbDataT   pwdata,
    input  logic [3:0]        pstrb,
    input  agcPkg::accumT     accum,
    input  agcPkg::gainWordT  gainOut0,
    input  agcPkg::gainWordT  gainOut1,
    output agcPkg::apbDataT   prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              zeroError,
    output logic              invertError,
    output logic              bypassAgc,
    output agcPkg::sampleMagT agcSetpoint,
    output agcPkg::loopGainT  posErrorGain,
    output agcPkg::loopGainT  negErrorGain,
    output agcPkg::accumT     upperLimit,
    output agcPkg::accumT     lowerLimit,
    output agcPkg::ratioT     ratio0,
    output agcPkg::ratioT     ratio1
);
    import agcPkg::*;

    logic    access;
    logic    writeEn;
    logic    mapped;
    logic    readOnly;
    apbDataT controlWord;
    apbDataT controlNext;
    apbDataT gainSnap;

    // old word with the strobed bytes replaced.
    function automatic apbDataT laneMerge(input apbDataT oldWord, input apbDataT newWord,
                                          input logic [3:0] strb);
        apbDataT merged;
        merged = oldWord;
        for (int lane = 0; lane < 4; lane++) begin
            if (strb[lane]) begin
                merged[lane*8 +: 8] = newWord[lane*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign access   = psel & penable;
    assign writeEn  = access & pwrite;
    assign mapped   = paddr inside {ADDR_CONTROL, ADDR_ULIMIT, ADDR_LLIMIT,
                                    ADDR_GAINS, ADDR_RATIOS, ADDR_ACCUM};
    assign readOnly = (paddr == ADDR_GAINS) || (paddr == ADDR_ACCUM);
    // no wait states.
    assign pready   = 1'b1;
    assign pslverr  = access & (~mapped | (pwrite & readOnly));

    // unused control bits read as zero.
    assign controlWord = {3'b000, negErrorGain, 3'b000, posErrorGain, agcSetpoint,
                          5'b00000, bypassAgc, invertError, zeroError};
    assign controlNext = laneMerge(controlWord, pwdata, pstrb);

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            zeroError    <= 1'b0;
            invertError  <= 1'b0;
            bypassAgc    <= 1'b0;
            agcSetpoint  <= RST_SETPOINT;
            posErrorGain <= RST_POS_GAIN;
            negErrorGain <= RST_NEG_GAIN;
        end else if (writeEn && paddr == ADDR_CONTROL) begin
            zeroError    <= controlNext[0];
            invertError  <= controlNext[1];
            bypassAgc    <= controlNext[2];
            agcSetpoint  <= controlNext[15:8];
            posErrorGain <= controlNext[20:16];
            negErrorGain <= controlNext[28:24];
        end
    end

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            upperLimit <= RST_ULIMIT;
            lowerLimit <= RST_LLIMIT;
            ratio0     <= RST_RATIO;
            ratio1     <= RST_RATIO;
        end else if (writeEn) begin
            if (paddr == ADDR_ULIMIT) begin
                upperLimit <= laneMerge(upperLimit, pwdata, pstrb);
            end
            if (paddr == ADDR_LLIMIT) begin
                lowerLimit <= laneMerge(lowerLimit, pwdata, pstrb);
            end
            if (paddr == ADDR_RATIOS) begin
                {ratio1, ratio0} <= laneMerge({ratio1, ratio0}, pwdata, pstrb);
            end
        end
    end

    // gain words are frozen while the bus has the block selected.
    always_ff @(posedge busClk) begin
        if (!psel) begin
            gainSnap <= {gainOut1, gainOut0};
        end
    end

    always_comb begin
        prdata = '0;
        if (access) begin
            case (paddr)
                ADDR_CONTROL: prdata = controlWord;
                ADDR_ULIMIT:  prdata = upperLimit;
                ADDR_LLIMIT:  prdata = lowerLimit;
                ADDR_GAINS:   prdata = gainSnap;
                ADDR_RATIOS:  prdata = {ratio1, ratio0};
                ADDR_ACCUM:   prdata = accum;
                default:      prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== agcPkg.sv ====
// Shared definitions for the AGC loop.
// Holds the APB register map, the register reset values,
// the ratio fraction width and the width typedefs.

`default_nettype none

package agcPkg;

    // bus and datapath widths.
    typedef logic [5:0]         apbAddrT;
    typedef logic [31:0]        apbDataT;
    typedef logic [7:0]         sampleMagT;
    typedef logic signed [8:0]  errorT;
    // 9-bit error shifted by up to 31 places.
    typedef logic signed [40:0] stepT;
    typedef logic [31:0]        accumT;
    typedef logic [4:0]         loopGainT;
    typedef logic [15:0]        ratioT;
    typedef logic [15:0]        gainWordT;

    // register byte addresses.
    localparam apbAddrT ADDR_CONTROL = 6'h00;
    localparam apbAddrT ADDR_ULIMIT  = 6'h04;
    localparam apbAddrT ADDR_LLIMIT  = 6'h08;
    localparam apbAddrT ADDR_GAINS   = 6'h0C;
    localparam apbAddrT ADDR_RATIOS  = 6'h10;
    localparam apbAddrT ADDR_ACCUM   = 6'h14;

    // register reset values.
    localparam sampleMagT RST_SETPOINT = 8'hE0;
    localparam loopGainT  RST_POS_GAIN = 5'h1B;
    localparam loopGainT  RST_NEG_GAIN = 5'h1B;
    localparam accumT     RST_ULIMIT   = 32'h4FFF_FFFF;
    localparam accumT     RST_LLIMIT   = 32'h0000_0000;
    localparam ratioT     RST_RATIO    = 16'h8000;

    // a ratio of 0x8000 is unity.
    localparam int RATIO_FRAC_BITS = 15;

endpackage

`default_nettype wire
